//--- common/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    localparam int CMD_WORDS = 5;
    localparam int PIX_W     = 16;
    localparam int FRAC_BITS = 8;
    localparam int ACC_W     = 40;

    // Codes 4 to 7 are reserved, the controller skips them
    typedef enum logic [2:0] {
        OP_IDLE    = 3'd0,
        OP_CONV3   = 3'd1,
        OP_CONV3_1 = 3'd2,
        OP_POOL3   = 3'd3
    } op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COLLECT,
        ST_ISSUE,
        ST_WAIT,
        ST_FINISH
    } csb_state_e;

    // Signed Q8.8 sample, full product, and wide accumulator
    typedef logic signed [PIX_W-1:0]   pix_t;
    typedef logic signed [2*PIX_W-1:0] prod_t;
    typedef logic signed [ACC_W-1:0]   acc_t;

    typedef struct packed {
        op_e         op;
        pix_t [0:8]  tap;
        pix_t [0:8]  w3x3;
        pix_t        b3x3;
        pix_t        pix1x1;
        pix_t        w1x1;
        pix_t        b1x1;
        logic [31:0] w_addr;
    } operand_t;

    typedef struct packed {
        op_e         op;
        logic [31:0] w_addr;
        pix_t        value_3x3;
        pix_t        value_1x1;
    } result_t;

    function automatic acc_t sum_prod9(input prod_t [0:8] p);
        acc_t acc;
        acc = '0;
        for (int i = 0; i < 9; i++) begin
            acc += p[i];
        end
        return acc;
    endfunction

    // Products are Q16.16, so the bias is aligned before the rescale
    function automatic pix_t mac_relu(input acc_t prod_sum, input pix_t bias);
        acc_t bias_ext;
        acc_t scaled;
        bias_ext = bias;
        scaled   = (prod_sum + (bias_ext <<< FRAC_BITS)) >>> FRAC_BITS;
        if (scaled < 0) begin
            return '0;
        end
        if (scaled > acc_t'(32767)) begin
            return 16'sd32767;
        end
        return scaled[PIX_W-1:0];
    endfunction

    function automatic pix_t max_pix(input pix_t a, input pix_t b);
        return (a > b) ? a : b;
    endfunction

endpackage

`default_nettype wire

//--- rtl/cmd_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_fifo #(
    parameter int DEPTH = 16
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        wr,
    input  wire logic [31:0] wdata,
    input  wire logic        rd,
    output logic      [31:0] rdata,
    output logic             full,
    output logic             empty
);

    localparam int AW = $clog2(DEPTH);

    logic [31:0]   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign full  = (count == (AW+1)'(DEPTH));
    assign empty = (count == '0);

    // Requests against a full or empty buffer are dropped
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    // Head word is visible without a read cycle
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- csb/csb_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module csb_ctrl import cnn_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        op_en,
    input  wire logic [31:0] fifo_rdata,
    input  wire logic        fifo_empty,
    output logic             fifo_rd,
    input  wire logic [31:0] data,
    input  wire logic [31:0] weightbias,
    output logic             data_rd_en,
    output logic             weight_rd_en,
    output logic      [31:0] r_addr,
    output logic             fire,
    output operand_t         operands,
    input  wire logic        done,
    output logic             irq
);

    csb_state_e state;
    csb_state_e state_nxt;

    logic [2:0] cmd_cnt;
    logic [3:0] data_cnt;
    logic [3:0] wb_cnt;
    logic [3:0] data_len;
    logic [3:0] wb_len;
    logic       op_ok;
    logic       last_word;
    logic       issue_last;
    logic       skipped;

    // Stream reads per opcode, zero marks an opcode that is skipped
    always_comb begin
        case (operands.op)
            OP_CONV3: begin
                data_len = 4'd5;
                wb_len   = 4'd6;
            end
            OP_CONV3_1: begin
                data_len = 4'd6;
                wb_len   = 4'd8;
            end
            OP_POOL3: begin
                data_len = 4'd5;
                wb_len   = 4'd0;
            end
            default: begin
                data_len = 4'd0;
                wb_len   = 4'd0;
            end
        endcase
    end

    assign op_ok     = (data_len != 4'd0);
    assign fifo_rd   = (state == ST_COLLECT) && !fifo_empty;
    assign last_word = fifo_rd && (cmd_cnt == 3'(CMD_WORDS - 1));

    // Data and weight streams run side by side, issue ends with the longer one
    assign data_rd_en   = (state == ST_ISSUE) && (data_cnt < data_len);
    assign weight_rd_en = (state == ST_ISSUE) && (wb_cnt < wb_len);
    assign issue_last   = (!data_rd_en || (data_cnt == data_len - 4'd1)) &&
                          (!weight_rd_en || (wb_cnt == wb_len - 4'd1));

    assign irq = (state == ST_FINISH);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (op_en) begin
                    state_nxt = ST_COLLECT;
                end
            end
            ST_COLLECT: begin
                if (last_word) begin
                    state_nxt = op_ok ? ST_ISSUE : ST_COLLECT;
                end else if (skipped && fifo_empty) begin
                    state_nxt = ST_FINISH;
                end
            end
            ST_ISSUE: begin
                if (issue_last) begin
                    state_nxt = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (done) begin
                    state_nxt = fifo_empty ? ST_FINISH : ST_COLLECT;
                end
            end
            ST_FINISH: begin
                if (!op_en) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            cmd_cnt  <= '0;
            data_cnt <= '0;
            wb_cnt   <= '0;
            r_addr   <= '0;
            fire     <= 1'b0;
            skipped  <= 1'b0;
        end else begin
            state <= state_nxt;
            fire  <= (state == ST_ISSUE) && issue_last;

            if (state != ST_COLLECT) begin
                skipped <= 1'b0;
            end
            if (fifo_rd) begin
                skipped <= 1'b0;
                if (last_word) begin
                    cmd_cnt <= '0;
                    // Remember a skip so a drained FIFO ends the run
                    skipped <= !op_ok;
                end else begin
                    cmd_cnt <= cmd_cnt + 3'd1;
                end
                if (cmd_cnt == 3'd3) begin
                    r_addr <= fifo_rdata;
                end
            end

            if (state != ST_ISSUE) begin
                data_cnt <= '0;
                wb_cnt   <= '0;
            end else begin
                if (data_rd_en) begin
                    data_cnt <= data_cnt + 4'd1;
                    r_addr   <= r_addr + 32'd4;
                end
                if (weight_rd_en) begin
                    wb_cnt <= wb_cnt + 4'd1;
                end
            end
        end
    end

    // Operand bundle, words 1 and 2 and the stride bytes are not kept
    always_ff @(posedge clk) begin
        if (fifo_rd && cmd_cnt == 3'd0) begin
            operands.op <= op_e'(fifo_rdata[2:0]);
        end
        if (last_word) begin
            operands.w_addr <= fifo_rdata;
        end

        if (data_rd_en) begin
            case (data_cnt)
                4'd0, 4'd1, 4'd2, 4'd3: begin
                    operands.tap[{data_cnt[1:0], 1'b0}] <= data[31:16];
                    operands.tap[{data_cnt[1:0], 1'b1}] <= data[15:0];
                end
                4'd4:    operands.tap[8] <= data[15:0];
                default: operands.pix1x1 <= data[15:0];
            endcase
        end

        if (weight_rd_en) begin
            case (wb_cnt)
                4'd0, 4'd1, 4'd2, 4'd3: begin
                    operands.w3x3[{wb_cnt[1:0], 1'b0}] <= weightbias[31:16];
                    operands.w3x3[{wb_cnt[1:0], 1'b1}] <= weightbias[15:0];
                end
                4'd4: operands.w3x3[8] <= weightbias[15:0];
                4'd5: begin
                    // Plain 3x3 conv ends with its bias, the 1x1 variant with w1x1
                    if (operands.op == OP_CONV3) begin
                        operands.b3x3 <= weightbias[15:0];
                    end else begin
                        operands.w1x1 <= weightbias[15:0];
                    end
                end
                4'd6:    operands.b3x3 <= weightbias[15:0];
                default: operands.b1x1 <= weightbias[15:0];
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pe/conv_engine.sv
`timescale 1ns/10ps
`default_nettype none

module conv_engine import cnn_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     fire,
    input  wire operand_t operands,
    output logic          done,
    output result_t       result
);

    // Stage 1 holds the products, stage 2 the finished result
    logic             s1_valid;
    prod_t [0:8]      s1_prod3;
    prod_t            s1_prod1;
    pix_t             s1_b3x3;
    pix_t             s1_b1x1;
    op_e              s1_op;
    logic [31:0]      s1_w_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= fire;
            done     <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            for (int i = 0; i < 9; i++) begin
                s1_prod3[i] <= operands.tap[i] * operands.w3x3[i];
            end
            s1_prod1  <= operands.pix1x1 * operands.w1x1;
            s1_b3x3   <= operands.b3x3;
            s1_b1x1   <= operands.b1x1;
            s1_op     <= operands.op;
            s1_w_addr <= operands.w_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            result.op        <= s1_op;
            result.w_addr    <= s1_w_addr;
            result.value_3x3 <= mac_relu(sum_prod9(s1_prod3), s1_b3x3);
            // 1x1 path only reported for the combined opcode
            if (s1_op == OP_CONV3_1) begin
                result.value_1x1 <= mac_relu(s1_prod1, s1_b1x1);
            end else begin
                result.value_1x1 <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- pe/pool_max_engine.sv
`timescale 1ns/10ps
`default_nettype none

module pool_max_engine import cnn_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire operand_t operands,
    input  wire logic     fire,
    output logic          done,
    output result_t       result
);

    pix_t        max_lo;
    pix_t        max_hi;
    logic        s1_valid;
    pix_t        s1_max_lo;
    pix_t        s1_max_hi;
    op_e         s1_op;
    logic [31:0] s1_w_addr;

    // Split the window in two halves, taps 0-4 and taps 5-8
    always_comb begin
        max_lo = operands.tap[0];
        for (int i = 1; i < 5; i++) begin
            max_lo = max_pix(max_lo, operands.tap[i]);
        end
        max_hi = operands.tap[5];
        for (int i = 6; i < 9; i++) begin
            max_hi = max_pix(max_hi, operands.tap[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= fire;
            done     <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            s1_max_lo <= max_lo;
            s1_max_hi <= max_hi;
            s1_op     <= operands.op;
            s1_w_addr <= operands.w_addr;
        end
        if (s1_valid) begin
            result.op        <= s1_op;
            result.w_addr    <= s1_w_addr;
            result.value_3x3 <= max_pix(s1_max_lo, s1_max_hi);
            result.value_1x1 <= '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cnn_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module cnn_core_top import cnn_pkg::*; #(
    parameter int CMD_DEPTH = 16
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        op_en,
    input  wire logic        cmd_wr,
    input  wire logic [31:0] cmd_wdata,
    output logic             cmd_full,
    input  wire logic [31:0] data,
    input  wire logic [31:0] weightbias,
    output logic             data_rd_en,
    output logic             weight_rd_en,
    output logic      [31:0] r_addr,
    output logic             result_valid,
    output result_t          result,
    output logic             irq
);

    logic [31:0] fifo_rdata;
    logic        fifo_empty;
    logic        fifo_rd;
    logic        fire;
    logic        conv_fire;
    logic        pool_fire;
    logic        conv_done;
    logic        pool_done;
    logic        done;
    operand_t    operands;
    result_t     conv_result;
    result_t     pool_result;

    cmd_fifo #(
        .DEPTH (CMD_DEPTH)
    ) cmd_fifo_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (cmd_wr),
        .wdata (cmd_wdata),
        .rd    (fifo_rd),
        .rdata (fifo_rdata),
        .full  (cmd_full),
        .empty (fifo_empty)
    );

    csb_ctrl csb_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .op_en        (op_en),
        .fifo_rdata   (fifo_rdata),
        .fifo_empty   (fifo_empty),
        .fifo_rd      (fifo_rd),
        .data         (data),
        .weightbias   (weightbias),
        .data_rd_en   (data_rd_en),
        .weight_rd_en (weight_rd_en),
        .r_addr       (r_addr),
        .fire         (fire),
        .operands     (operands),
        .done         (done),
        .irq          (irq)
    );

    // Route the fire pulse to the engine that owns the opcode
    assign conv_fire = fire && (operands.op == OP_CONV3 || operands.op == OP_CONV3_1);
    assign pool_fire = fire && (operands.op == OP_POOL3);

    conv_engine conv_engine_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .fire     (conv_fire),
        .operands (operands),
        .done     (conv_done),
        .result   (conv_result)
    );

    pool_max_engine pool_max_engine_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .operands (operands),
        .fire     (pool_fire),
        .done     (pool_done),
        .result   (pool_result)
    );

    // One engine finishes at a time
    assign done         = conv_done | pool_done;
    assign result_valid = done;
    assign result       = pool_done ? pool_result : conv_result;

endmodule

`default_nettype wire

//--- tests/cnn_core_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module cnn_core_asserts import cnn_pkg::*; (
    input wire logic       clk,
    input wire logic       rst_n,
    input wire logic       op_en,
    input wire csb_state_e state,
    input wire logic       irq,
    input wire logic       data_rd_en,
    input wire logic       weight_rd_en,
    input wire logic       fire,
    input wire logic       done
);

    // Completion level holds while the host keeps op_en up
    irq_held: assert property (@(posedge clk) disable iff (!rst_n)
        irq && op_en |=> irq)
        else $error("irq dropped while op_en was still high");

    // Fire comes in the cycle after the last stream read
    fire_after_reads: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(data_rd_en || weight_rd_en) |-> fire && state == ST_WAIT)
        else $error("fire missing after the last stream read");

    // Both engines are two stages deep
    done_after_fire: assert property (@(posedge clk) disable iff (!rst_n)
        done == $past(fire, 2))
        else $error("done does not follow fire by two cycles");

endmodule

bind csb_ctrl cnn_core_asserts cnn_core_asserts_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_en        (op_en),
    .state        (state),
    .irq          (irq),
    .data_rd_en   (data_rd_en),
    .weight_rd_en (weight_rd_en),
    .fire         (fire),
    .done         (done)
);

`default_nettype wire

//--- tests/tb_cnn_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cnn_core import cnn_pkg::*; ();

    localparam int CMD_DEPTH = 16;
    localparam int TIMEOUT   = 200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        op_en;
    logic        cmd_wr;
    logic [31:0] cmd_wdata;
    logic        cmd_full;
    logic [31:0] data;
    logic [31:0] weightbias;
    logic        data_rd_en;
    logic        weight_rd_en;
    logic [31:0] r_addr;
    logic        result_valid;
    result_t     result;
    logic        irq;

    logic [31:0] data_q[$];
    logic [31:0] weight_q[$];
    logic        data_pend   = 1'b0;
    logic        weight_pend = 1'b0;
    int          data_pops   = 0;
    int          weight_pops = 0;
    int          checks      = 0;
    int          errors      = 0;
    int          seed        = 16673;

    cnn_core_top #(
        .CMD_DEPTH (CMD_DEPTH)
    ) cnn_core_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .op_en        (op_en),
        .cmd_wr       (cmd_wr),
        .cmd_wdata    (cmd_wdata),
        .cmd_full     (cmd_full),
        .data         (data),
        .weightbias   (weightbias),
        .data_rd_en   (data_rd_en),
        .weight_rd_en (weight_rd_en),
        .r_addr       (r_addr),
        .result_valid (result_valid),
        .result       (result),
        .irq          (irq)
    );

    always #50 clk = ~clk;

    // Stream heads move on the falling edge, one pop per sampled rd_en
    always @(negedge clk) begin
        if (data_pend) begin
            data_pops++;
            if (data_q.size() == 0) begin
                errors++;
                $display("Data stream was read past its last word at %0t ns", $time);
            end else begin
                void'(data_q.pop_front());
            end
        end
        if (weight_pend) begin
            weight_pops++;
            if (weight_q.size() == 0) begin
                errors++;
                $display("Weight stream was read past its last word at %0t ns", $time);
            end else begin
                void'(weight_q.pop_front());
            end
        end
        data        = (data_q.size() != 0) ? data_q[0] : 32'h0;
        weightbias  = (weight_q.size() != 0) ? weight_q[0] : 32'h0;
        data_pend   = data_rd_en;
        weight_pend = weight_rd_en;
    end

    task automatic check_result(input result_t got, input result_t want, input string name);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string name);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic check_addr(input logic [31:0] got, input logic [31:0] want,
                              input string name);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_count(input int got, input int want, input string name);
        checks++;
        if (got != want) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, want);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    // Reference convolution: Q16.16 product sum, then the shared rescale
    function automatic pix_t ref_conv(input pix_t a[9], input pix_t b[9], input pix_t bias);
        acc_t acc;
        acc = '0;
        for (int i = 0; i < 9; i++) begin
            acc = acc + acc_t'(a[i]) * acc_t'(b[i]);
        end
        return mac_relu(acc, bias);
    endfunction

    function automatic pix_t ref_max(input pix_t a[9]);
        pix_t m;
        m = a[0];
        for (int i = 1; i < 9; i++) begin
            if (a[i] > m) begin
                m = a[i];
            end
        end
        return m;
    endfunction

    // Roughly +-3.0 in Q8.8 so that random sums rarely saturate
    function automatic pix_t rand_pix();
        return pix_t'($random(seed) % 768);
    endfunction

    task automatic push_nine(input pix_t v[9], input bit to_weight);
        logic [31:0] w;
        for (int k = 0; k < 5; k++) begin
            w = (k < 4) ? {v[2*k], v[2*k+1]} : {16'h5a5a, v[8]};
            if (to_weight) begin
                weight_q.push_back(w);
            end else begin
                data_q.push_back(w);
            end
        end
    endtask

    task automatic push_low(input pix_t v, input bit to_weight);
        if (to_weight) begin
            weight_q.push_back({16'ha5a5, v});
        end else begin
            data_q.push_back({16'ha5a5, v});
        end
    endtask

    task automatic write_cmd(input logic [2:0] op, input logic [31:0] d_addr,
                             input logic [31:0] wb_addr, input int first);
        logic [31:0] words [CMD_WORDS];
        // Stride and channel fields carry junk, only bits 2:0 matter
        words[0] = {29'h01C1_A200, op};
        words[1] = 32'h0010_0010;
        words[2] = 32'h0008_0000;
        words[3] = d_addr;
        words[4] = wb_addr;
        for (int i = first; i < CMD_WORDS; i++) begin
            @(negedge clk);
            cmd_wr    = 1'b1;
            cmd_wdata = words[i];
        end
        @(negedge clk);
        cmd_wr = 1'b0;
    endtask

    task automatic wait_result(output result_t r);
        int n;
        n = 0;
        @(negedge clk);
        while (!result_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!result_valid) begin
            errors++;
            $display("Timed out waiting for result_valid at %0t ns", $time);
        end else begin
            r = result;
        end
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while (irq !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (irq !== level) begin
            errors++;
            $display("Timed out waiting for irq to become %0b at %0t ns", level, $time);
        end
    endtask

    task automatic start_run();
        @(negedge clk);
        op_en = 1'b1;
    endtask

    // irq must hold until op_en drops, then clear
    task automatic end_run();
        wait_irq(1'b1);
        repeat (2) begin
            @(negedge clk);
            check_flag(irq, 1'b1, "irq");
        end
        op_en = 1'b0;
        @(negedge clk);
        wait_irq(1'b0);
    endtask

    task automatic run_single(input op_e op, input pix_t tap[9], input pix_t w3[9],
                              input pix_t b3, input pix_t pix1, input pix_t w1,
                              input pix_t b1, input logic [31:0] d_addr,
                              input logic [31:0] wb_addr);
        result_t want;
        result_t got;
        int      d0;
        int      w0;
        int      n_data;
        int      n_weight;
        d0             = data_pops;
        w0             = weight_pops;
        want.op        = op;
        want.w_addr    = wb_addr;
        want.value_1x1 = '0;
        push_nine(tap, 1'b0);
        if (op == OP_POOL3) begin
            want.value_3x3 = ref_max(tap);
            n_data         = 5;
            n_weight       = 0;
        end else begin
            want.value_3x3 = ref_conv(tap, w3, b3);
            push_nine(w3, 1'b1);
            if (op == OP_CONV3) begin
                push_low(b3, 1'b1);
                n_data   = 5;
                n_weight = 6;
            end else begin
                push_low(pix1, 1'b0);
                push_low(w1, 1'b1);
                push_low(b3, 1'b1);
                push_low(b1, 1'b1);
                want.value_1x1 = mac_relu(acc_t'(pix1) * acc_t'(w1), b1);
                n_data         = 6;
                n_weight       = 8;
            end
        end
        write_cmd(op, d_addr, wb_addr, 0);
        start_run();
        wait_result(got);
        check_result(got, want, "result");
        end_run();
        check_count(data_pops - d0, n_data, "data words read");
        check_count(weight_pops - w0, n_weight, "weight words read");
        check_addr(r_addr, d_addr + 32'(4 * n_data), "r_addr");
    endtask

    task automatic conv3_random_and_limits();
        pix_t tap[9];
        pix_t w[9];
        for (int i = 0; i < 9; i++) begin
            tap[i] = rand_pix();
            w[i]   = rand_pix();
        end
        run_single(OP_CONV3, tap, w, rand_pix(), '0, '0, '0, 32'h0000_4000, 32'h8000_0100);
        // -9.0 plus 0.5 bias clamps to zero
        for (int i = 0; i < 9; i++) begin
            tap[i] = 16'sh0100;
            w[i]   = 16'shff00;
        end
        run_single(OP_CONV3, tap, w, 16'sh0080, '0, '0, '0, 32'h0000_4100, 32'h8000_0200);
        // 9 x 127.0 is far past the positive limit
        for (int i = 0; i < 9; i++) begin
            tap[i] = 16'sh7f00;
            w[i]   = 16'sh0100;
        end
        run_single(OP_CONV3, tap, w, 16'sh1000, '0, '0, '0, 32'h0000_4200, 32'h8000_0300);
    endtask

    task automatic conv3_with_1x1();
        pix_t tap[9];
        pix_t w[9];
        for (int i = 0; i < 9; i++) begin
            tap[i] = rand_pix();
            w[i]   = rand_pix();
        end
        run_single(OP_CONV3_1, tap, w, rand_pix(), 16'sh0280, 16'sh0140, 16'shffc0,
                   32'h0000_5000, 32'h8000_0400);
    endtask

    // All taps negative, r_addr lands 20 bytes past the data start
    task automatic pool_negative_taps();
        pix_t tap[9];
        pix_t w[9];
        for (int i = 0; i < 9; i++) begin
            tap[i] = rand_pix() - 16'sd800;
            w[i]   = '0;
        end
        run_single(OP_POOL3, tap, w, '0, '0, '0, '0, 32'h0000_6000, 32'h8000_0500);
    endtask

    task automatic queued_with_skip();
        pix_t    ta[9];
        pix_t    wa[9];
        pix_t    tc[9];
        result_t got;
        result_t want_a;
        result_t want_c;
        int      d0;
        int      w0;
        for (int i = 0; i < 9; i++) begin
            ta[i] = rand_pix();
            wa[i] = rand_pix();
            tc[i] = rand_pix();
        end
        d0 = data_pops;
        w0 = weight_pops;
        push_nine(ta, 1'b0);
        push_nine(wa, 1'b1);
        push_low(16'sh0040, 1'b1);
        push_nine(tc, 1'b0);
        want_a.op        = OP_CONV3;
        want_a.w_addr    = 32'h0000_a000;
        want_a.value_3x3 = ref_conv(ta, wa, 16'sh0040);
        want_a.value_1x1 = '0;
        want_c.op        = OP_POOL3;
        want_c.w_addr    = 32'h0000_c000;
        want_c.value_3x3 = ref_max(tc);
        want_c.value_1x1 = '0;
        write_cmd(3'd1, 32'h0000_0100, 32'h0000_a000, 0);
        write_cmd(3'd5, 32'h0000_0200, 32'h0000_b000, 0);
        write_cmd(3'd3, 32'h0000_0300, 32'h0000_c000, 0);
        start_run();
        wait_result(got);
        check_result(got, want_a, "first queued result");
        check_flag(irq, 1'b0, "irq");
        wait_result(got);
        check_result(got, want_c, "second queued result");
        end_run();
        check_count(data_pops - d0, 10, "data words read");
        check_count(weight_pops - w0, 6, "weight words read");
        check_addr(r_addr, 32'h0000_0314, "r_addr");
    endtask

    // Sixteen words fit, so the fourth command keeps only its opcode word
    task automatic fifo_overflow();
        pix_t    t[9];
        result_t got;
        result_t want;
        int      d0;
        for (int i = 0; i < 9; i++) begin
            t[i] = rand_pix();
        end
        d0 = data_pops;
        for (int c = 0; c < 4; c++) begin
            push_nine(t, 1'b0);
        end
        for (int c = 0; c < 4; c++) begin
            write_cmd(3'd3, 32'h0000_7000, 32'h0000_d000 + 32'(16 * c), 0);
        end
        check_flag(cmd_full, 1'b1, "cmd_full");
        want.op        = OP_POOL3;
        want.value_3x3 = ref_max(t);
        want.value_1x1 = '0;
        start_run();
        for (int c = 0; c < 3; c++) begin
            want.w_addr = 32'h0000_d000 + 32'(16 * c);
            wait_result(got);
            check_result(got, want, "pool result from full FIFO");
        end
        for (int n = 0; n < 20; n++) begin
            @(negedge clk);
            check_flag(result_valid | irq, 1'b0, "result_valid or irq");
        end
        write_cmd(3'd3, 32'h0000_7000, 32'h0000_e000, 1);
        want.w_addr = 32'h0000_e000;
        wait_result(got);
        check_result(got, want, "completed fourth result");
        end_run();
        check_count(data_pops - d0, 20, "data words read");
        check_flag(cmd_full, 1'b0, "cmd_full");
    endtask

    initial begin
        rst_n      = 1'b0;
        op_en      = 1'b0;
        cmd_wr     = 1'b0;
        cmd_wdata  = 32'h0;
        data       = 32'h0;
        weightbias = 32'h0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_flag(irq, 1'b0, "irq");
        check_flag(result_valid, 1'b0, "result_valid");
        check_flag(data_rd_en | weight_rd_en, 1'b0, "rd_en");
        conv3_random_and_limits();
        conv3_with_1x1();
        pool_negative_taps();
        queued_with_skip();
        fifo_overflow();
        repeat (4) @(negedge clk);
        check_count(data_q.size(), 0, "unread data words");
        check_count(weight_q.size(), 0, "unread weight words");
        finish_run();
    end

endmodule

`default_nettype wire

//--- filelist.f
common/cnn_pkg.sv
rtl/cmd_fifo.sv
csb/csb_ctrl.sv
pe/conv_engine.sv
pe/pool_max_engine.sv
rtl/cnn_core_top.sv
tests/cnn_core_asserts.sv
tests/tb_cnn_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cnn_core \
    -f filelist.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^No errors$" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
